// File: flist.f
+incdir+include
rtl/dotp_pkg.sv
rtl/dotp_pipe_stage.sv
rtl/dotp_round_pack.sv
rtl/dotp_sdotp_core.sv
rtl/dotp_wrapper.sv
rtl/dotp_unit_top.sv
test/dotp_unit_assert.sv
test/tb_dotp_unit.sv

// File: include/dotp_defs.svh
// Widths shared by the dot-product unit and its testbench.
// Include this file in any source that sizes operands, the accumulator or the tag.

`ifndef DOTP_DEFS_SVH
`define DOTP_DEFS_SVH

// operand word and result, FP16
`define DOTP_DST_W 16

// one FP8 lane, E5M2 or E4M3
`define DOTP_SRC_W 8

// signed fixed point, LSB weighs 2^-40, top magnitude bit 2^38, plus sign
`define DOTP_ACC_W 80

// user tag carried along with each operation
`define DOTP_TAG_W 4

`endif

// File: rtl/dotp_pipe_stage.sv
// One valid/ready register slice with flush.
// Chained back to back to build every pipeline stage of the unit;
// ready runs combinationally from the output side back to the input.

`default_nettype none
`timescale 1ns/1ps

module dotp_pipe_stage #(
  parameter int unsigned DataWidth = 1
) (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  logic                 flush_i,   // drops whatever the slice holds
  input  logic                 valid_i,
  output logic                 ready_o,
  input  logic [DataWidth-1:0] data_i,
  output logic                 valid_o,
  input  logic                 ready_i,
  output logic [DataWidth-1:0] data_o
);

  logic                 valid_q;
  logic [DataWidth-1:0] data_q;   // payload, no reset needed
  logic                 load;

  assign ready_o = ready_i | ~valid_q;  // empty or draining this cycle
  assign load    = valid_i & ready_o;

  // valid bit
  always_ff @(posedge clk_i) begin
    if (reset_i || flush_i) begin
      valid_q <= 1'b0;
    end else if (ready_o) begin
      valid_q <= valid_i;  // take new item or go empty
    end
  end

  // payload only moves on a load
  always_ff @(posedge clk_i) begin
    if (load) begin
      data_q <= data_i;
    end
  end

  assign valid_o = valid_q;
  assign data_o  = data_q;

endmodule

`default_nettype wire

// File: rtl/dotp_pkg.sv
// Types for the dot-product unit: operation, FP8 source format,
// rounding mode and the IEEE status flags.
// Modules import it in their body and use scoped names on their ports.

`default_nettype none

package dotp_pkg;

  // --------------------
  // operation select
  // --------------------
  typedef enum logic {
    SDOTP = 1'b0,  // a*b + c*d + e
    VSUM  = 1'b1   // sum of three fp16 words
  } operation_e;

  // fp8 layout of the multiplicands
  typedef enum logic {
    FP8    = 1'b0,  // e5m2, bias 15
    FP8ALT = 1'b1   // e4m3, bias 7
  } src_fmt_e;

  typedef enum logic {
    RNE = 1'b0,  // nearest, ties to even
    RTZ = 1'b1   // toward zero
  } roundmode_e;

  // --------------------
  // status flags
  // --------------------
  typedef struct packed {
    logic nv;  // invalid, nan or inf input
    logic dz;  // never set, no division here
    logic of;  // overflow
    logic uf;  // underflow, flushed to zero
    logic nx;  // inexact
  } status_t;

endpackage

`default_nettype wire

// File: rtl/dotp_round_pack.sv
// Normalizes the signed fixed-point sum, rounds it once to FP16 and
// applies the nan, overflow, underflow and zero rules. Purely combinational,
// the core registers its outputs in the last pipeline stage.

`default_nettype none
`timescale 1ns/1ps
`include "dotp_defs.svh"

module dotp_round_pack (
  input  logic [`DOTP_ACC_W-1:0] acc_i,          // two's complement, LSB = 2^-40
  input  logic                   special_nan_i,  // some input was nan or inf
  input  dotp_pkg::roundmode_e   rnd_mode_i,
  output logic [`DOTP_DST_W-1:0] result_o,
  output dotp_pkg::status_t      status_o
);

  import dotp_pkg::*;

  logic                   sign;
  logic [`DOTP_ACC_W-1:0] mag;
  logic [`DOTP_ACC_W-1:0] norm;      // leading one moved to the msb
  logic [6:0]             lead;      // leading one position
  logic [10:0]            sig;       // hidden bit plus 10 mantissa bits
  logic                   guard;
  logic                   sticky;
  logic                   round_up;
  logic [11:0]            sig_r;     // one extra bit for the rounding carry
  logic [9:0]             man;
  logic signed [8:0]      exp_u;     // unbiased, after rounding

  // --------------------
  // magnitude and lzc
  // --------------------
  assign sign = acc_i[`DOTP_ACC_W-1];
  assign mag  = sign ? -acc_i : acc_i;

  always_comb begin
    lead = '0;
    for (int i = 0; i < `DOTP_ACC_W; i++) begin
      if (mag[i]) lead = 7'(i);  // last hit wins, so the highest one
    end
  end

  assign norm = mag << (7'(`DOTP_ACC_W - 1) - lead);

  // --------------------
  // rounding
  // --------------------
  assign sig      = norm[`DOTP_ACC_W-1 -: 11];
  assign guard    = norm[`DOTP_ACC_W-12];
  assign sticky   = |norm[`DOTP_ACC_W-13:0];
  assign round_up = (rnd_mode_i == RNE) & guard & (sticky | sig[0]);  // rtz never rounds up
  assign sig_r    = {1'b0, sig} + 12'(round_up);
  assign man      = sig_r[11] ? sig_r[10:1] : sig_r[9:0];  // carry gives 1.000..

  // bit 40 of the accumulator weighs 2^0
  assign exp_u = $signed({2'b00, lead}) - 9'sd40 + $signed({8'b0, sig_r[11]});

  // --------------------
  // special cases
  // --------------------
  always_comb begin
    result_o = {sign, 5'(exp_u + 9'sd15), man};  // rebias to 15
    status_o = '0;
    if (special_nan_i) begin
      result_o    = 16'h7E00;  // canonical nan
      status_o.nv = 1'b1;
    end else if (mag == '0) begin
      result_o = '0;  // exact zero is always +0
    end else if (exp_u > 9'sd15) begin
      // at or above 2^16
      result_o    = (rnd_mode_i == RNE) ? {sign, 15'h7C00} : {sign, 15'h7BFF};
      status_o.of = 1'b1;
      status_o.nx = 1'b1;
    end else if (exp_u < -9'sd14) begin
      result_o    = {sign, 15'h0000};  // no subnormal outputs
      status_o.uf = 1'b1;
      status_o.nx = 1'b1;
    end else begin
      status_o.nx = guard | sticky;
    end
  end

endmodule

`default_nettype wire

// File: rtl/dotp_sdotp_core.sv
// Three-stage datapath of the dot-product unit.
// Stage 1 holds the decoded products or fp16 addends, stage 2 the exact
// fixed-point sum, stage 3 the rounded fp16 result with flags and tag.
// Inputs come lane-sliced from the wrapper; op_i picks products or addends.

`default_nettype none
`timescale 1ns/1ps
`include "dotp_defs.svh"

module dotp_sdotp_core (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  logic [`DOTP_SRC_W-1:0] operand_a_i,
  input  logic [`DOTP_SRC_W-1:0] operand_b_i,
  input  logic [`DOTP_SRC_W-1:0] operand_c_i,
  input  logic [`DOTP_SRC_W-1:0] operand_d_i,
  input  logic [`DOTP_DST_W-1:0] addend0_i,      // vsum only
  input  logic [`DOTP_DST_W-1:0] addend1_i,      // vsum only
  input  logic [`DOTP_DST_W-1:0] dst_operand_i,  // always the third term
  input  dotp_pkg::operation_e   op_i,
  input  dotp_pkg::src_fmt_e     src_fmt_i,
  input  dotp_pkg::roundmode_e   rnd_mode_i,
  input  logic [`DOTP_TAG_W-1:0] tag_i,
  input  logic                   in_valid_i,
  output logic                   in_ready_o,
  input  logic                   flush_i,
  output logic [`DOTP_DST_W-1:0] result_o,
  output dotp_pkg::status_t      status_o,
  output logic [`DOTP_TAG_W-1:0] tag_o,
  output logic                   out_valid_o,
  input  logic                   out_ready_i,
  output logic                   busy_o
);

  import dotp_pkg::*;

  logic [3:0][`DOTP_SRC_W-1:0] fp8_op;   // a, b, c, d
  logic [3:0]                  fp8_spc, fp8_dnz;
  logic [3:0][4:0]             fp8_exp;  // rebiased to 15 for both formats
  logic [3:0][3:0]             fp8_sig;  // 1.mmm, zero if subnormal
  logic [1:0][7:0]             prod;
  logic [2:0][`DOTP_DST_W-1:0] fp16_op;
  logic [2:0]                  fp16_spc;
  logic [2:0][10:0]            fp16_sig;
  logic [2:0]                  t_sgn, s1_sgn;
  logic [2:0][10:0]            t_sig, s1_sig;
  logic [2:0][6:0]             t_sh, s1_sh;   // accumulator bit of the term lsb
  logic                        t_nan, s1_nan, s2_nan, s1_rnd, s2_rnd;
  logic [`DOTP_TAG_W-1:0]      s1_tag, s2_tag;
  logic [2:0][`DOTP_ACC_W-1:0] s2_term;
  logic [`DOTP_ACC_W-1:0]      acc_d, s2_acc;
  logic [`DOTP_DST_W-1:0]      rp_result;
  status_t                     rp_status;
  logic [`DOTP_TAG_W+58:0]                      s1_in, s1_data;
  logic [`DOTP_ACC_W+`DOTP_TAG_W+1:0]           s2_in, s2_data;
  logic [`DOTP_DST_W+$bits(status_t)+`DOTP_TAG_W-1:0] s3_in, s3_data;
  logic s1_valid, s2_valid, s3_valid, s2_ready, s3_ready;

  // --------------------
  // stage 1 decode
  // --------------------
  assign fp8_op  = {operand_d_i, operand_c_i, operand_b_i, operand_a_i};
  assign fp16_op = {dst_operand_i, addend1_i, addend0_i};

  always_comb begin
    for (int i = 0; i < 4; i++) begin
      if (src_fmt_i == FP8) begin  // e5m2, pad mantissa to 3 bits
        fp8_spc[i] = &fp8_op[i][6:2];
        fp8_dnz[i] = fp8_op[i][6:2] == '0;
        fp8_exp[i] = fp8_op[i][6:2];
        fp8_sig[i] = {1'b1, fp8_op[i][1:0], 1'b0};
      end else begin               // e4m3
        fp8_spc[i] = &fp8_op[i][6:3];
        fp8_dnz[i] = fp8_op[i][6:3] == '0;
        fp8_exp[i] = {1'b0, fp8_op[i][6:3]} + 5'd8;
        fp8_sig[i] = {1'b1, fp8_op[i][2:0]};
      end
      if (fp8_dnz[i]) begin        // subnormal counts as zero
        fp8_exp[i] = '0;
        fp8_sig[i] = '0;
      end
    end
    for (int i = 0; i < 3; i++) begin
      fp16_spc[i] = &fp16_op[i][14:10];
      fp16_sig[i] = (fp16_op[i][14:10] == '0) ? 11'd0 : {1'b1, fp16_op[i][9:0]};
    end
  end

  assign prod[0] = fp8_sig[0] * fp8_sig[1];  // exact 8 bit
  assign prod[1] = fp8_sig[2] * fp8_sig[3];

  // term select, fp16 lsb at bit e+15, product lsb at bit ea+eb+4
  always_comb begin
    t_sgn[2] = fp16_op[2][15];
    t_sig[2] = fp16_sig[2];
    t_sh[2]  = {2'b00, fp16_op[2][14:10]} + 7'd15;
    if (op_i == VSUM) begin
      for (int i = 0; i < 2; i++) begin
        t_sgn[i] = fp16_op[i][15];
        t_sig[i] = fp16_sig[i];
        t_sh[i]  = {2'b00, fp16_op[i][14:10]} + 7'd15;
      end
      t_nan = |fp16_spc;
    end else begin
      for (int i = 0; i < 2; i++) begin
        t_sgn[i] = fp8_op[2*i][7] ^ fp8_op[2*i+1][7];
        t_sig[i] = {3'b000, prod[i]};
        t_sh[i]  = {2'b00, fp8_exp[2*i]} + {2'b00, fp8_exp[2*i+1]} + 7'd4;
      end
      t_nan = (|fp8_spc) | fp16_spc[2];
    end
  end

  assign s1_in = {t_nan, rnd_mode_i, tag_i, t_sgn, t_sig, t_sh};

  dotp_pipe_stage #(.DataWidth(`DOTP_TAG_W+59)) u_stage1 (
    .clk_i, .reset_i, .flush_i,
    .valid_i (in_valid_i), .ready_o (in_ready_o), .data_i (s1_in),
    .valid_o (s1_valid),   .ready_i (s2_ready),   .data_o (s1_data)
  );

  assign {s1_nan, s1_rnd, s1_tag, s1_sgn, s1_sig, s1_sh} = s1_data;

  // --------------------
  // stage 2 align, add
  // --------------------
  always_comb begin
    acc_d = '0;
    for (int i = 0; i < 3; i++) begin
      s2_term[i] = {{(`DOTP_ACC_W-11){1'b0}}, s1_sig[i]} << s1_sh[i];
      if (s1_sgn[i]) acc_d = acc_d - s2_term[i];
      else           acc_d = acc_d + s2_term[i];
    end
  end

  assign s2_in = {s1_nan, s1_rnd, s1_tag, acc_d};

  dotp_pipe_stage #(.DataWidth(`DOTP_ACC_W+`DOTP_TAG_W+2)) u_stage2 (
    .clk_i, .reset_i, .flush_i,
    .valid_i (s1_valid), .ready_o (s2_ready), .data_i (s2_in),
    .valid_o (s2_valid), .ready_i (s3_ready), .data_o (s2_data)
  );

  assign {s2_nan, s2_rnd, s2_tag, s2_acc} = s2_data;

  // --------------------
  // stage 3 round
  // --------------------
  dotp_round_pack u_round_pack (
    .acc_i         (s2_acc),
    .special_nan_i (s2_nan),
    .rnd_mode_i    (roundmode_e'(s2_rnd)),
    .result_o      (rp_result),
    .status_o      (rp_status)
  );

  assign s3_in = {rp_result, rp_status, s2_tag};

  dotp_pipe_stage #(.DataWidth(`DOTP_DST_W+$bits(status_t)+`DOTP_TAG_W)) u_stage3 (
    .clk_i, .reset_i, .flush_i,
    .valid_i (s2_valid), .ready_o (s3_ready),    .data_i (s3_in),
    .valid_o (s3_valid), .ready_i (out_ready_i), .data_o (s3_data)
  );

  assign {result_o, status_o, tag_o} = s3_data;
  assign out_valid_o = s3_valid;
  assign busy_o      = s1_valid | s2_valid | s3_valid;  // anything in flight

endmodule

`default_nettype wire

// File: rtl/dotp_unit_top.sv
// Top level of the expanding dot-product unit.
// Exposes the operand words, handshakes, flush and busy to the system.

`default_nettype none
`timescale 1ns/1ps
`include "dotp_defs.svh"

module dotp_unit_top (
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  logic [2:0][`DOTP_DST_W-1:0] operands_i,  // word 2 is the fp16 addend
  input  dotp_pkg::operation_e        op_i,
  input  dotp_pkg::src_fmt_e          src_fmt_i,
  input  dotp_pkg::roundmode_e        rnd_mode_i,
  input  logic [`DOTP_TAG_W-1:0]      tag_i,
  input  logic                        in_valid_i,
  output logic                        in_ready_o,
  input  logic                        flush_i,
  output logic [`DOTP_DST_W-1:0]      result_o,
  output dotp_pkg::status_t           status_o,
  output logic [`DOTP_TAG_W-1:0]      tag_o,
  output logic                        out_valid_o,
  input  logic                        out_ready_i,
  output logic                        busy_o
);

  // --------------------
  // datapath
  // --------------------
  dotp_wrapper u_dotp_wrapper (
    .clk_i, .reset_i, .operands_i, .op_i, .src_fmt_i, .rnd_mode_i, .tag_i,
    .in_valid_i, .in_ready_o, .flush_i,
    .result_o, .status_o, .tag_o, .out_valid_o, .out_ready_i, .busy_o
  );

endmodule

`default_nettype wire

// File: rtl/dotp_wrapper.sv
// Operand steering in front of the dot-product core.
// Cuts the FP8 lanes out of words 0 and 1 for SDOTP, or passes those words
// on as FP16 addends for VSUM. Word 2 always goes in as the FP16 addend.

`default_nettype none
`timescale 1ns/1ps
`include "dotp_defs.svh"

module dotp_wrapper (
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  logic [2:0][`DOTP_DST_W-1:0] operands_i,
  input  dotp_pkg::operation_e        op_i,
  input  dotp_pkg::src_fmt_e          src_fmt_i,
  input  dotp_pkg::roundmode_e        rnd_mode_i,
  input  logic [`DOTP_TAG_W-1:0]      tag_i,
  input  logic                        in_valid_i,
  output logic                        in_ready_o,
  input  logic                        flush_i,
  output logic [`DOTP_DST_W-1:0]      result_o,
  output dotp_pkg::status_t           status_o,
  output logic [`DOTP_TAG_W-1:0]      tag_o,
  output logic                        out_valid_o,
  input  logic                        out_ready_i,
  output logic                        busy_o
);

  import dotp_pkg::*;

  // lane-local operands
  logic [`DOTP_SRC_W-1:0] op_a, op_b, op_c, op_d;
  logic [`DOTP_DST_W-1:0] addend0, addend1;
  logic [`DOTP_DST_W-1:0] dst_operand;

  assign dst_operand = operands_i[2];  // e in sdotp, third addend in vsum

  always_comb begin
    if (op_i == VSUM) begin
      // multiplicands unused, all ones marks the bypass
      op_a    = '1;
      op_b    = '1;
      op_c    = '1;
      op_d    = '1;
      addend0 = operands_i[0];
      addend1 = operands_i[1];
    end else begin
      op_a    = operands_i[0][`DOTP_SRC_W-1:0];            // low byte
      op_b    = operands_i[1][`DOTP_SRC_W-1:0];
      op_c    = operands_i[0][`DOTP_DST_W-1 -: `DOTP_SRC_W];  // high byte
      op_d    = operands_i[1][`DOTP_DST_W-1 -: `DOTP_SRC_W];
      addend0 = '0;
      addend1 = '0;
    end
  end

  dotp_sdotp_core u_dotp_sdotp_core (
    .clk_i,
    .reset_i,
    .operand_a_i   (op_a),
    .operand_b_i   (op_b),
    .operand_c_i   (op_c),
    .operand_d_i   (op_d),
    .addend0_i     (addend0),
    .addend1_i     (addend1),
    .dst_operand_i (dst_operand),
    .op_i,
    .src_fmt_i,   // fp8 layout of a..d
    .rnd_mode_i,
    .tag_i,
    .in_valid_i,
    .in_ready_o,
    .flush_i,
    .result_o,
    .status_o,
    .tag_o,
    .out_valid_o,
    .out_ready_i,
    .busy_o
  );

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# build the testbench with Verilator, run it, pass only if the pass message shows up
verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module tb_dotp_unit \
  -Mdir obj_dir -o sim \
  && ./obj_dir/sim +verilator+error+limit+100 | tee /dev/stderr \
  | grep -F '*** PASSED ***' > /dev/null \
  && echo "run.sh: simulation passed" \
  || { echo "run.sh: simulation failed"; exit 1; }

// File: test/dotp_unit_assert.sv
// Concurrent checks on the handshake and reset behavior of the dot-product unit.
// Bound to dotp_unit_top, so every port name matches the DUT's own.

`default_nettype none
`timescale 1ns/1ps
`include "dotp_defs.svh"

module dotp_unit_assert (
  input logic                   clk_i,
  input logic                   reset_i,
  input logic                   flush_i,
  input logic [`DOTP_DST_W-1:0] result_o,
  input dotp_pkg::status_t      status_o,
  input logic [`DOTP_TAG_W-1:0] tag_o,
  input logic                   out_valid_o,
  input logic                   out_ready_i,
  input logic                   busy_o
);

  int fail_cnt = 0;  // failed checks, read at end of run

  // --------------------
  // reset empties all stages
  reset_empty: assert property (@(posedge clk_i) reset_i |=> !out_valid_o && !busy_o)
    else begin
      fail_cnt++;
      $error("out_valid_o or busy_o high in the cycle after reset");
    end

  // result held while the sink stalls
  stall_stable: assert property (@(posedge clk_i) disable iff (reset_i)
      (out_valid_o && !out_ready_i && !flush_i) |=>
      (out_valid_o && $stable(result_o) && $stable(status_o) && $stable(tag_o)))
    else begin
      fail_cnt++;
      $error("output changed or dropped while out_ready_i was low");
    end

  // flush drops every stage on the next edge
  flush_empty: assert property (@(posedge clk_i) disable iff (reset_i)
      flush_i |=> !busy_o && !out_valid_o)
    else begin
      fail_cnt++;
      $error("busy_o or out_valid_o still high in the cycle after flush");
    end

endmodule

bind dotp_unit_top dotp_unit_assert u_dotp_unit_assert (.*);

`default_nettype wire

// File: test/tb_dotp_unit.sv
// Directed testbench for the dot-product unit.
// Covers reset and latency, SDOTP, VSUM, special cases, back-pressure and flush.
// Expected values come from a real-number model that rounds once to FP16.

`default_nettype none
`timescale 1ns/1ps
`include "dotp_defs.svh"

module tb_dotp_unit;

  import dotp_pkg::*;

  localparam int num_ops  = 126;  // operations issued over all tests
  localparam int cycle_ns = 100;

  logic                        clk_i;
  logic                        reset_i;
  logic [2:0][`DOTP_DST_W-1:0] operands_i;
  operation_e                  op_i;
  src_fmt_e                    src_fmt_i;
  roundmode_e                  rnd_mode_i;
  logic [`DOTP_TAG_W-1:0]      tag_i;
  logic                        in_valid_i;
  logic                        in_ready_o;
  logic                        flush_i;
  logic [`DOTP_DST_W-1:0]      result_o;
  status_t                     status_o;
  logic [`DOTP_TAG_W-1:0]      tag_o;
  logic                        out_valid_o;
  logic                        out_ready_i;
  logic                        busy_o;

  int unsigned lcg_state;
  int          err_cnt, test_start, n_tests, n_ops, total;

  dotp_unit_top u_dotp_unit_top (.*);

  always #(cycle_ns / 2) clk_i = ~clk_i;

  // --------------------
  // stimulus helpers
  function automatic int unsigned next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state >> 16;  // upper bits, better period
  endfunction

  // exponent windows kept narrow so every exact sum fits a real
  function automatic logic [7:0] rand_fp8(input src_fmt_e fmt);
    int unsigned r;
    r = next_rand();
    if (fmt == FP8) begin
      return {r[0], 5'(13 + (r >> 3) % 5), r[2:1]};  // unbiased -2..2
    end
    return {r[0], 4'(5 + (r >> 4) % 5), r[3:1]};
  endfunction

  function automatic logic [15:0] rand_fp16();
    int unsigned r;
    r = next_rand();
    return {r[0], 5'(12 + (r >> 11) % 7), r[10:1]};  // unbiased -3..3
  endfunction

  // --------------------
  // reference model
  function automatic real pow2(input int n);
    real p;
    p = 1.0;
    for (int i = 0; i < n; i++) p = p * 2.0;
    for (int i = 0; i > n; i--) p = p / 2.0;
    return p;
  endfunction

  function automatic real fp8_val(input logic [7:0] b, input src_fmt_e fmt);
    real v;
    if (fmt == FP8) begin
      v = (b[6:2] == 0) ? 0.0 : (4.0 + b[1:0]) / 4.0 * pow2(int'(b[6:2]) - 15);
    end else begin
      v = (b[6:3] == 0) ? 0.0 : (8.0 + b[2:0]) / 8.0 * pow2(int'(b[6:3]) - 7);
    end
    return b[7] ? -v : v;  // subnormals already zero
  endfunction

  function automatic real fp16_val(input logic [15:0] w);
    real v;
    v = (w[14:10] == 0) ? 0.0 : (1024.0 + w[9:0]) / 1024.0 * pow2(int'(w[14:10]) - 15);
    return w[15] ? -v : v;
  endfunction

  task automatic round_to_fp16(input real x, input roundmode_e rnd,
                               output logic [15:0] res, output status_t st);
    real         m, frac;
    int          e;
    int unsigned fi;
    logic        sgn;
    st  = '0;
    sgn = x < 0.0;
    m   = sgn ? -x : x;
    e   = 0;
    if (m == 0.0) begin
      res = 16'h0000;  // exact zero is +0
    end else begin
      while (m >= 2.0) begin
        m = m / 2.0;
        e++;
      end
      while (m < 1.0) begin
        m = m * 2.0;
        e--;
      end
      m    = m * 1024.0;  // 11 significant bits above the point
      fi   = $rtoi(m);
      frac = m - fi;
      if (rnd == RNE && (frac > 0.5 || (frac == 0.5 && fi[0]))) fi++;
      if (fi == 2048) begin  // carry out of the significand
        fi = 1024;
        e++;
      end
      st.nx = frac != 0.0;
      if (e > 15) begin
        res   = (rnd == RNE) ? {sgn, 15'h7C00} : {sgn, 15'h7BFF};
        st.of = 1'b1;
        st.nx = 1'b1;
      end else if (e < -14) begin
        res   = {sgn, 15'h0000};  // no subnormal results
        st.uf = 1'b1;
        st.nx = 1'b1;
      end else begin
        res = {sgn, 5'(e + 15), fi[9:0]};
      end
    end
  endtask

  // --------------------
  // compare tasks
  task automatic check_result(input logic [`DOTP_DST_W-1:0] got, input logic [`DOTP_DST_W-1:0] exp);
    if (got !== exp) begin
      $display("error: t=%0t result_o got %h expected %h", $time, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_status(input status_t got, input status_t exp);
    if (got !== exp) begin
      $display("error: t=%0t status_o got %b expected %b", $time, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_tag(input logic [`DOTP_TAG_W-1:0] got, input logic [`DOTP_TAG_W-1:0] exp);
    if (got !== exp) begin
      $display("error: t=%0t tag_o got %h expected %h", $time, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("error: t=%0t %s got %b expected %b", $time, name, got, exp);
      err_cnt++;
    end
  endtask

  // --------------------
  // bus tasks, entered and left on a falling edge
  task automatic send_op(input logic [15:0] w0, input logic [15:0] w1, input logic [15:0] w2,
                         input operation_e op, input src_fmt_e fmt, input roundmode_e rnd,
                         input logic [`DOTP_TAG_W-1:0] tag);
    int n;
    operands_i = {w2, w1, w0};
    op_i       = op;
    src_fmt_i  = fmt;
    rnd_mode_i = rnd;
    tag_i      = tag;
    in_valid_i = 1'b1;
    n          = 0;
    n_ops++;
    #1;  // let in_ready_o settle
    while (!in_ready_o && n < 50) begin
      @(negedge clk_i);
      #1;
      n++;
    end
    if (!in_ready_o) begin
      $display("error: t=%0t operation with tag %h never accepted", $time, tag);
      err_cnt++;
    end
    @(posedge clk_i);  // transfer edge
    @(negedge clk_i);
    in_valid_i = 1'b0;
  endtask

  task automatic get_result(output logic [15:0] res, output status_t st, output logic [3:0] tg);
    int n;
    out_ready_i = 1'b1;
    n           = 0;
    while (!out_valid_o && n < 50) begin
      @(negedge clk_i);
      n++;
    end
    if (!out_valid_o) begin
      $display("error: t=%0t no result came out within 50 cycles", $time);
      err_cnt++;
    end
    res = result_o;
    st  = status_o;
    tg  = tag_o;
    @(posedge clk_i);
    @(negedge clk_i);
  endtask

  task automatic run_op(input logic [15:0] w0, input logic [15:0] w1, input logic [15:0] w2,
                        input operation_e op, input src_fmt_e fmt, input roundmode_e rnd,
                        input logic [3:0] tag, input logic [15:0] exp_res, input status_t exp_st);
    logic [15:0] res;
    status_t     st;
    logic [3:0]  tg;
    send_op(w0, w1, w2, op, fmt, rnd, tag);
    get_result(res, st, tg);
    check_result(res, exp_res);
    check_status(st, exp_st);
    check_tag(tg, tag);
  endtask

  task automatic begin_test();
    test_start = err_cnt;
    n_tests++;
  endtask

  task automatic end_test(input string name);
    $display("test %-16s done at %0t ns, %0d errors", name, $time, err_cnt - test_start);
  endtask

  // --------------------
  // directed tests
  task automatic test_reset_latency();
    int          lat;
    logic [15:0] res;
    status_t     st;
    logic [3:0]  tg;
    begin_test();
    check_bit("out_valid_o", out_valid_o, 1'b0);
    check_bit("busy_o", busy_o, 1'b0);
    check_bit("in_ready_o", in_ready_o, 1'b1);
    out_ready_i = 1'b1;
    send_op(16'h003C, 16'h003C, 16'h3C00, SDOTP, FP8, RNE, 4'd5);  // 1*1 + 0*0 + 1
    lat = 1;  // accepting edge counts as the first
    while (!out_valid_o && lat < 10) begin
      @(posedge clk_i);
      @(negedge clk_i);
      lat++;
    end
    if (lat != 3) begin
      $display("error: t=%0t out_valid_o latency got %0d expected 3", $time, lat);
      err_cnt++;
    end
    get_result(res, st, tg);
    check_result(res, 16'h4000);
    check_status(st, '0);
    check_tag(tg, 4'd5);
    end_test("reset_latency");
  endtask

  task automatic test_sdotp(input src_fmt_e fmt, input roundmode_e rnd);
    logic [7:0]  a, b, c, d;
    logic [15:0] e, exp_res;
    status_t     exp_st;
    real         x;
    begin_test();
    for (int i = 0; i < 20; i++) begin
      a = rand_fp8(fmt);
      b = rand_fp8(fmt);
      c = rand_fp8(fmt);
      d = rand_fp8(fmt);
      e = rand_fp16();
      x = fp8_val(a, fmt) * fp8_val(b, fmt) + fp8_val(c, fmt) * fp8_val(d, fmt) + fp16_val(e);
      round_to_fp16(x, rnd, exp_res, exp_st);
      run_op({c, a}, {d, b}, e, SDOTP, fmt, rnd, 4'(i), exp_res, exp_st);
    end
    end_test($sformatf("sdotp_%s_%s", fmt.name(), rnd.name()));
  endtask

  task automatic test_vsum();
    logic [15:0] w0, w1, w2, exp_res;
    status_t     exp_st;
    roundmode_e  rnd;
    begin_test();
    for (int i = 0; i < 20; i++) begin
      w0  = rand_fp16();
      w1  = rand_fp16();
      w2  = rand_fp16();
      rnd = i[0] ? RTZ : RNE;  // alternate modes
      round_to_fp16(fp16_val(w0) + fp16_val(w1) + fp16_val(w2), rnd, exp_res, exp_st);
      run_op(w0, w1, w2, VSUM, FP8, rnd, 4'(i), exp_res, exp_st);
    end
    w0 = rand_fp16();
    run_op(w0, w0 ^ 16'h8000, 16'h8000, VSUM, FP8, RTZ, 4'hF, 16'h0000, '0);  // x - x - 0
    end_test("vsum");
  endtask

  task automatic test_special();
    begin_test();
    // flag order nv dz of uf nx
    run_op({8'h3C, 8'h7F}, 16'h3C3C, 16'h3C00, SDOTP, FP8, RNE, 4'd1,
           16'h7E00, status_t'(5'b10000));                          // fp8 nan in a
    run_op(16'h7C00, 16'h3C00, 16'h0000, VSUM, FP8, RNE, 4'd2,
           16'h7E00, status_t'(5'b10000));                          // fp16 inf
    run_op(16'h7BFF, 16'h7BFF, 16'h0000, VSUM, FP8, RNE, 4'd3,
           16'h7C00, status_t'(5'b00101));
    run_op(16'h7BFF, 16'h7BFF, 16'h0000, VSUM, FP8, RTZ, 4'd4,
           16'h7BFF, status_t'(5'b00101));                          // clamps to max
    run_op(16'h0004, 16'h0004, 16'h0000, SDOTP, FP8, RNE, 4'd5,
           16'h0000, status_t'(5'b00011));                          // 2^-28
    end_test("special");
  endtask

  task automatic test_backpressure();
    logic [15:0] w0 [16];
    logic [15:0] w1 [16];
    logic [15:0] w2 [16];
    logic [15:0] exp_res [16];
    status_t     exp_st [16];
    begin_test();
    for (int i = 0; i < 16; i++) begin
      w0[i] = {rand_fp8(FP8ALT), rand_fp8(FP8ALT)};
      w1[i] = {rand_fp8(FP8ALT), rand_fp8(FP8ALT)};
      w2[i] = rand_fp16();
      round_to_fp16(fp8_val(w0[i][7:0], FP8ALT) * fp8_val(w1[i][7:0], FP8ALT)
                    + fp8_val(w0[i][15:8], FP8ALT) * fp8_val(w1[i][15:8], FP8ALT)
                    + fp16_val(w2[i]), RNE, exp_res[i], exp_st[i]);
    end
    fork
      begin : issue
        for (int i = 0; i < 16; i++) send_op(w0[i], w1[i], w2[i], SDOTP, FP8ALT, RNE, 4'(i));
      end
      begin : collect
        int          k, n;
        int unsigned r;
        k = 0;
        n = 0;
        while (k < 16 && n < 400) begin
          r           = next_rand();
          out_ready_i = r[3];  // random stall
          #1;
          if (out_valid_o && out_ready_i) begin
            check_result(result_o, exp_res[k]);
            check_status(status_o, exp_st[k]);
            check_tag(tag_o, 4'(k));
            k++;
          end
          @(negedge clk_i);
          n++;
        end
        if (k < 16) begin
          $display("error: t=%0t only %0d of 16 burst results arrived", $time, k);
          err_cnt++;
        end
      end
    join
    check_bit("out_valid_o", out_valid_o, 1'b0);  // nothing extra left
    check_bit("busy_o", busy_o, 1'b0);
    out_ready_i = 1'b1;
    end_test("backpressure");
  endtask

  task automatic test_flush();
    begin_test();
    out_ready_i = 1'b0;  // keep both items inside
    send_op(16'h3C3C, 16'h3C3C, 16'h3C00, SDOTP, FP8, RNE, 4'd1);
    send_op(16'h4040, 16'h3C3C, 16'h0000, SDOTP, FP8, RNE, 4'd2);
    check_bit("busy_o", busy_o, 1'b1);
    flush_i = 1'b1;
    @(posedge clk_i);
    @(negedge clk_i);
    flush_i = 1'b0;
    check_bit("busy_o", busy_o, 1'b0);
    out_ready_i = 1'b1;
    repeat (5) begin
      @(negedge clk_i);
      check_bit("out_valid_o", out_valid_o, 1'b0);
    end
    run_op(16'h0000, 16'h0000, 16'h4200, SDOTP, FP8ALT, RTZ, 4'd3, 16'h4200, '0);  // e alone
    end_test("flush");
  endtask

  // --------------------
  // main sequence
  initial begin
    clk_i      = 1'b0;
    reset_i    = 1'b1;
    operands_i = '0;
    op_i       = SDOTP;
    src_fmt_i  = FP8;
    rnd_mode_i = RNE;
    tag_i      = '0;
    in_valid_i = 1'b0;
    flush_i    = 1'b0;
    out_ready_i = 1'b1;
    lcg_state  = 57;
    err_cnt    = 0;
    n_tests    = 0;
    n_ops      = 0;
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;
    @(negedge clk_i);
    test_reset_latency();
    test_sdotp(FP8, RNE);
    test_sdotp(FP8, RTZ);
    test_sdotp(FP8ALT, RNE);
    test_sdotp(FP8ALT, RTZ);
    test_vsum();
    test_special();
    test_backpressure();
    test_flush();
    total = err_cnt + u_dotp_unit_top.u_dotp_unit_assert.fail_cnt;
    $display("summary: %0d tests, %0d operations, %0d check errors, %0d assertion failures",
             n_tests, n_ops, err_cnt, u_dotp_unit_top.u_dotp_unit_assert.fail_cnt);
    if (total == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  // watchdog, 200 cycles per operation
  initial begin
    #(num_ops * 200 * cycle_ns);
    $display("watchdog: run did not finish within %0d cycles", num_ops * 200);
    $display("*** FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire
